// File: design/dcache_pkg.sv
// dcache shared definitions: geometry, field widths, request structs, controller states
package dcache_pkg;

    // address and data geometry
    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 64;
    localparam int MASK_W   = WORD_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    // replacement age counters
    localparam int AGE_W   = 3;
    localparam int AGE_MAX = (1 << AGE_W) - 1;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [MASK_W-1:0]  mask_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [AGE_W-1:0]   age_t;
    typedef logic               way_t;

    // cpu load/store request, only one of rd and wr set
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        mask_t mask;
    } cpu_req_t;

    // word-wide memory port request
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        REFILL,
        FILL,
        RESPOND
    } cache_state_e;

endpackage

// File: design/dcache_age.sv
// dcache age counters: saturating per-way ages per set and LRU victim choice
`timescale 1ns/100ps

module dcache_age import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     index_i,
    input  logic       touch_i,
    input  way_t       way_i,
    input  logic [1:0] valid_i,
    output way_t       victim_o
);

    age_t age_q [2][NUM_SETS];
    age_t age0;
    age_t age1;
    age_t other_age;

    assign age0      = age_q[0][index_i];
    assign age1      = age_q[1][index_i];
    assign other_age = age_q[~way_i][index_i];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                age_q[0][s] <= '0;
                age_q[1][s] <= '0;
            end
        end else if (touch_i) begin
            // touched way becomes youngest
            age_q[way_i][index_i] <= '0;
            if (other_age != age_t'(AGE_MAX)) begin
                age_q[~way_i][index_i] <= other_age + age_t'(1);
            end
        end
    end

    // free way first, else the older one, way 0 on a tie
    always_comb begin
        if (!valid_i[0]) begin
            victim_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_o = 1'b1;
        end else begin
            victim_o = (age1 > age0);
        end
    end

endmodule

// File: design/dcache_tag_store.sv
// dcache tag store: per-way tags with valid and dirty bits and hit detection
`timescale 1ns/100ps

module dcache_tag_store import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     index_i,
    input  tag_t       tag_i,
    input  logic       we_i,
    input  way_t       way_i,
    input  logic       set_dirty_i,
    output logic       hit_o,
    output way_t       hit_way_o,
    output logic [1:0] valid_o,
    output logic [1:0] dirty_o,
    output tag_t       tag0_o,
    output tag_t       tag1_o
);

    tag_t                     tag_q [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [1:0]               way_hit;

    // tag arrays
    always_ff @(posedge clk) begin
        if (we_i) tag_q[way_i][index_i] <= tag_i;
    end

    // a fill sets valid and takes the dirty bit as given
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we_i) begin
            valid_q[way_i][index_i] <= 1'b1;
            dirty_q[way_i][index_i] <= set_dirty_i;
        end else if (set_dirty_i) begin
            dirty_q[way_i][index_i] <= 1'b1;
        end
    end

    assign tag0_o = tag_q[0][index_i];
    assign tag1_o = tag_q[1][index_i];

    assign valid_o = {valid_q[1][index_i], valid_q[0][index_i]};
    assign dirty_o = {dirty_q[1][index_i], dirty_q[0][index_i]};

    assign way_hit[0] = valid_o[0] && (tag0_o == tag_i);
    assign way_hit[1] = valid_o[1] && (tag1_o == tag_i);

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // a tag never lives in both ways of one set
    a_single_hit: assert property (@(posedge clk) disable iff (!rst)
        !(way_hit[0] && way_hit[1]));

    // dirty lines are always valid ones
    a_dirty_valid: assert property (@(posedge clk) disable iff (!rst)
        ((dirty_o & ~valid_o) == 2'b00));

endmodule

// File: design/dcache_data_store.sv
// dcache data store: two word arrays with byte-masked writes and dual way-selected reads
`timescale 1ns/100ps

module dcache_data_store import dcache_pkg::*; (
    input  logic   clk,
    input  index_t index_i,
    input  way_t   way_i,
    input  mask_t  we_i,
    input  word_t  wdata_i,
    output word_t  rdata_o,
    input  way_t   victim_way_i,
    output word_t  victim_data_o
);

    word_t way0_q [NUM_SETS];
    word_t way1_q [NUM_SETS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < MASK_W; b++) begin
            if (we_i[b]) begin
                if (way_i) begin
                    way1_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end else begin
                    way0_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // load data from the target way
    assign rdata_o = way_i ? way1_q[index_i] : way0_q[index_i];

    // writeback data from the eviction candidate
    assign victim_data_o = victim_way_i ? way1_q[index_i] : way0_q[index_i];

endmodule

// File: design/dcache_ctrl.sv
// dcache controller: request latch, hit/miss FSM, writeback and refill over the memory port
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_req_t   req_i,
    input  logic       mem_ok_i,
    input  word_t      mem_rdata_i,
    input  logic       hit_i,
    input  way_t       hit_way_i,
    input  logic [1:0] valid_i,
    input  logic [1:0] dirty_i,
    input  way_t       victim_i,
    input  tag_t       victim_tag_i,
    input  word_t      victim_data_i,
    input  word_t      read_data_i,
    output index_t     index_o,
    output tag_t       tag_o,
    output way_t       way_o,
    output logic       tag_we_o,
    output logic       set_dirty_o,
    output mask_t      data_we_o,
    output word_t      data_wr_o,
    output logic       touch_o,
    output word_t      rdata_o,
    output logic       done_o,
    output mem_req_t   mem_req_o
);

    cache_state_e state_q;
    cache_state_e state_d;
    cpu_req_t     req_q;
    way_t         way_q;
    word_t        refill_q;
    logic         victim_dirty;
    word_t        bit_mask;

    assign index_o = req_q.addr[OFFSET_W +: INDEX_W];
    assign tag_o   = req_q.addr[ADDR_W-1 -: TAG_W];

    // target way is decided in lookup, then held
    assign way_o        = (state_q == LOOKUP) ? (hit_i ? hit_way_i : victim_i) : way_q;
    assign victim_dirty = valid_i[victim_i] && dirty_i[victim_i];

    // byte mask widened to bits for the fill merge
    always_comb begin
        for (int b = 0; b < MASK_W; b++) begin
            bit_mask[8*b +: 8] = {8{req_q.mask[b]}};
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i.rd || req_i.wr) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i) state_d = RESPOND;
                else if (victim_dirty) state_d = WBACK;
                else state_d = REFILL;
            end
            WBACK:   if (mem_ok_i) state_d = REFILL;
            REFILL:  if (mem_ok_i) state_d = FILL;
            FILL:    state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            way_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) way_q <= way_o;
        end
    end

    // request and refill payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && (req_i.rd || req_i.wr)) req_q <= req_i;
        if (state_q == REFILL && mem_ok_i) refill_q <= mem_rdata_i;
    end

    // store writes: masked on hit, merged full word on fill
    always_comb begin
        tag_we_o    = 1'b0;
        set_dirty_o = 1'b0;
        data_we_o   = '0;
        data_wr_o   = req_q.wdata;
        if (state_q == LOOKUP && hit_i && req_q.wr) begin
            data_we_o   = req_q.mask;
            set_dirty_o = 1'b1;
        end else if (state_q == FILL) begin
            tag_we_o    = 1'b1;
            data_we_o   = '1;
            set_dirty_o = req_q.wr;
            if (req_q.wr) data_wr_o = (refill_q & ~bit_mask) | (req_q.wdata & bit_mask);
            else data_wr_o = refill_q;
        end
    end

    always_comb begin
        mem_req_o = '0;
        if (state_q == WBACK) begin
            mem_req_o.wr    = 1'b1;
            mem_req_o.addr  = {victim_tag_i, index_o, {OFFSET_W{1'b0}}};
            mem_req_o.wdata = victim_data_i;
        end else if (state_q == REFILL) begin
            mem_req_o.rd   = 1'b1;
            mem_req_o.addr = {tag_o, index_o, {OFFSET_W{1'b0}}};
        end
    end

    assign done_o  = (state_q == RESPOND);
    assign touch_o = done_o;
    assign rdata_o = (done_o && req_q.rd) ? read_data_i : '0;

    // memory port carries one direction at a time
    a_mem_one_dir: assert property (@(posedge clk) disable iff (!rst)
        !(mem_req_o.rd && mem_req_o.wr));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_o |=> !done_o);

endmodule

// File: design/dcache_top.sv
// dcache top: two-way write-back data cache built from controller, age, tag and data stores
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t req_i,
    output word_t    rdata_o,
    output logic     done_o,
    output mem_req_t mem_req_o,
    input  word_t    mem_rdata_i,
    input  logic     mem_ok_i
);

    index_t     index;
    tag_t       tag;
    way_t       way_sel;
    logic       tag_we;
    logic       set_dirty;
    mask_t      data_we;
    word_t      data_wr;
    logic       touch;
    logic       hit;
    way_t       hit_way;
    logic [1:0] valid;
    logic [1:0] dirty;
    tag_t       tag0;
    tag_t       tag1;
    way_t       victim;
    tag_t       victim_tag;
    word_t      victim_data;
    word_t      read_data;

    // tag of the way picked for eviction
    assign victim_tag = victim ? tag1 : tag0;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .mem_ok_i      (mem_ok_i),
        .mem_rdata_i   (mem_rdata_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .valid_i       (valid),
        .dirty_i       (dirty),
        .victim_i      (victim),
        .victim_tag_i  (victim_tag),
        .victim_data_i (victim_data),
        .read_data_i   (read_data),
        .index_o       (index),
        .tag_o         (tag),
        .way_o         (way_sel),
        .tag_we_o      (tag_we),
        .set_dirty_o   (set_dirty),
        .data_we_o     (data_we),
        .data_wr_o     (data_wr),
        .touch_o       (touch),
        .rdata_o       (rdata_o),
        .done_o        (done_o),
        .mem_req_o     (mem_req_o)
    );

    dcache_age u_age (
        .clk      (clk),
        .rst      (rst),
        .index_i  (index),
        .touch_i  (touch),
        .way_i    (way_sel),
        .valid_i  (valid),
        .victim_o (victim)
    );

    dcache_tag_store u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .index_i     (index),
        .tag_i       (tag),
        .we_i        (tag_we),
        .way_i       (way_sel),
        .set_dirty_i (set_dirty),
        .hit_o       (hit),
        .hit_way_o   (hit_way),
        .valid_o     (valid),
        .dirty_o     (dirty),
        .tag0_o      (tag0),
        .tag1_o      (tag1)
    );

    dcache_data_store u_data_store (
        .clk           (clk),
        .index_i       (index),
        .way_i         (way_sel),
        .we_i          (data_we),
        .wdata_i       (data_wr),
        .rdata_o       (read_data),
        .victim_way_i  (victim),
        .victim_data_o (victim_data)
    );

endmodule

// File: test/mem_model.sv
// behavioral main memory: word store with random response delay and traffic counters
`timescale 1ns/100ps

module mem_model import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req_i,
    output word_t    mem_rdata_o,
    output logic     mem_ok_o,
    output int       rd_count_o,
    output int       wr_count_o,
    output addr_t    last_wr_addr_o
);

    // unwritten words read back as address xor this pattern
    localparam word_t INIT_PATTERN = 64'h5A5A_5A5A_0000_0000;

    word_t  mem [addr_t];
    integer seed;
    int     wait_cnt;
    logic   busy;

    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) return mem[a];
        return a ^ INIT_PATTERN;
    endfunction

    initial begin
        seed           = 24288;
        mem_rdata_o    = '0;
        mem_ok_o       = 1'b0;
        rd_count_o     = 0;
        wr_count_o     = 0;
        last_wr_addr_o = '0;
        busy           = 1'b0;
        wait_cnt       = 0;
        forever begin
            @(posedge clk);
            #10;
            mem_ok_o = 1'b0;
            if (!rst) begin
                busy = 1'b0;
            end else if (busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    busy     = 1'b0;
                    mem_ok_o = 1'b1;
                    if (mem_req_i.rd) begin
                        mem_rdata_o = read_word(mem_req_i.addr);
                        rd_count_o++;
                    end else begin
                        mem[mem_req_i.addr] = mem_req_i.wdata;
                        last_wr_addr_o      = mem_req_i.addr;
                        wr_count_o++;
                    end
                end
            end else if (mem_req_i.rd || mem_req_i.wr) begin
                // answer 1 to 4 cycles after the request is seen
                busy     = 1'b1;
                wait_cnt = 1 + int'($unsigned($random(seed)) % 4);
            end
        end
    end

endmodule

// File: test/tb_dcache.sv
// dcache testbench: replays load/store operations from the stim file and checks data and traffic
`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();

    localparam int MAX_OPS = 32;
    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;
    cpu_req_t    req;
    word_t       rdata;
    logic        done;
    mem_req_t    mem_req;
    word_t       mem_rdata;
    logic        mem_ok;
    int          rd_count;
    int          wr_count;
    addr_t       last_wr_addr;
    logic [63:0] stim [8*MAX_OPS];
    int          mismatch_errs;
    int          other_errs;
    logic        timed_out;

    dcache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .rdata_o     (rdata),
        .done_o      (done),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ok_i    (mem_ok)
    );

    mem_model u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_req_i      (mem_req),
        .mem_rdata_o    (mem_rdata),
        .mem_ok_o       (mem_ok),
        .rd_count_o     (rd_count),
        .wr_count_o     (wr_count),
        .last_wr_addr_o (last_wr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string what, input word_t exp_v, input word_t act_v);
        assert (exp_v == act_v) else begin
            $display("mismatch %s: expected %h, actual %h", what, exp_v, act_v);
            mismatch_errs++;
        end
    endtask

    task automatic check_idle();
        assert (!done && !mem_req.rd && !mem_req.wr) else begin
            $display("done or a memory request was active before the first request");
            other_errs++;
        end
    endtask

    // one stim line: drive, wait for done, compare data and memory traffic
    task automatic run_op(input int n);
        int    base;
        int    cycles;
        int    rd_before;
        int    wr_before;
        int    rd_at_wr;
        logic  wr_seen;
        logic  seen;
        string name;
        base      = 8 * n;
        name      = $sformatf("op%0d", n);
        rd_before = rd_count;
        wr_before = wr_count;
        req.rd    = (stim[base] == 64'd1);
        req.wr    = (stim[base] == 64'd2);
        req.addr  = stim[base+1];
        req.wdata = stim[base+2];
        req.mask  = stim[base+3][7:0];
        cycles    = 0;
        seen      = 1'b0;
        wr_seen   = 1'b0;
        rd_at_wr  = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // reads already done when the writeback lands
            if (!wr_seen && wr_count != wr_before) begin
                wr_seen  = 1'b1;
                rd_at_wr = rd_count - rd_before;
            end
            seen = done;
        end
        if (!seen) begin
            $display("%s: done did not arrive within %0d cycles", name, TIMEOUT);
            other_errs++;
            timed_out = 1'b1;
        end else begin
            check_word({name, " rdata"}, stim[base+4], rdata);
            check_word({name, " mem reads"}, stim[base+5], 64'(rd_count - rd_before));
            check_word({name, " mem writes"}, stim[base+6], 64'(wr_count - wr_before));
            if (stim[base+6] != 64'd0) begin
                check_word({name, " write addr"}, stim[base+7], last_wr_addr);
                // the victim goes out before the refill read
                check_word({name, " reads before write"}, 64'd0, 64'(rd_at_wr));
            end
        end
        // request held through the done cycle
        @(posedge clk);
        #10;
        req = '0;
    endtask

    initial begin
        int n;
        mismatch_errs = 0;
        other_errs    = 0;
        timed_out     = 1'b0;
        rst           = 1'b0;
        req           = '0;
        for (int i = 0; i < 8 * MAX_OPS; i++) begin
            stim[i] = '0;
        end
        $readmemh("test/dcache_stim.txt", stim);
        repeat (3) begin
            @(posedge clk);
        end
        #10;
        rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #10;
        n = 0;
        while (n < MAX_OPS && stim[8*n] != 64'd0 && !timed_out) begin
            run_op(n);
            n++;
        end
        if (n == 0) begin
            $display("no operations were read from the stim file");
            other_errs++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
design/dcache_pkg.sv
design/dcache_age.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

// File: Makefile
# Verilator build and run for the dcache testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_dcache -o sim_dcache

run: compile
	./obj_dir/sim_dcache > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/dcache_stim.txt
// op (1 load, 2 store), addr, wdata, mask, expected rdata, mem reads, mem writes, last write addr
// unwritten memory words read back as the address xor 5a5a5a5a00000000
1 0000000000000010 0000000000000000 00 5a5a5a5a00000010 1 0 0000000000000000
1 0000000000000010 0000000000000000 00 5a5a5a5a00000010 0 0 0000000000000000
2 0000000000000010 1122334455667788 0f 0000000000000000 0 0 0000000000000000
1 0000000000000010 0000000000000000 00 5a5a5a5a55667788 0 0 0000000000000000
2 0000000000000210 aabbccddeeff0011 f0 0000000000000000 1 0 0000000000000000
1 0000000000000210 0000000000000000 00 aabbccdd00000210 0 0 0000000000000000
1 0000000000000010 0000000000000000 00 5a5a5a5a55667788 0 0 0000000000000000
1 0000000000000410 0000000000000000 00 5a5a5a5a00000410 1 1 0000000000000210
1 0000000000000010 0000000000000000 00 5a5a5a5a55667788 0 0 0000000000000000
1 0000000000000610 0000000000000000 00 5a5a5a5a00000610 1 0 0000000000000000
1 0000000000000210 0000000000000000 00 aabbccdd00000210 1 1 0000000000000010
1 0000000000000010 0000000000000000 00 5a5a5a5a55667788 1 0 0000000000000000
1 000000000000002d 0000000000000000 00 5a5a5a5a00000028 1 0 0000000000000000
2 000000000000002a ff00000000000099 81 0000000000000000 0 0 0000000000000000
1 0000000000000028 0000000000000000 00 ff5a5a5a00000099 0 0 0000000000000000
2 0000000000000048 0123456789abcdef ff 0000000000000000 1 0 0000000000000000
1 0000000000000048 0000000000000000 00 0123456789abcdef 0 0 0000000000000000
